//--- hw/panel_pkg.sv
`default_nettype none

package panel_pkg;

    // machine word and memory field widths
    localparam int word_bits = 12;
    localparam int field_bits = 3;

    // only the low address bits reach the small core memory
    localparam int mem_words = 256;
    localparam int addr_bits = $clog2(mem_words);

    localparam int display_count = 6;
    localparam int key_count = 7;
    localparam int led_bits = 5;

    // 2**20 cycles is roughly 20 ms with a 50 MHz clock
    localparam int hold_bits_default = 20;

    // selector indicator patterns, one per display source
    localparam logic [led_bits-1:0] led_pc = 5'b01100;
    localparam logic [led_bits-1:0] led_ma = 5'b01010;
    localparam logic [led_bits-1:0] led_mb = 5'b01001;
    localparam logic [led_bits-1:0] led_ac = 5'b10100;
    localparam logic [led_bits-1:0] led_fields = 5'b10010;
    localparam logic [led_bits-1:0] led_sr = 5'b10001;

    typedef logic [word_bits-1:0] word_t;

    // key flags sit below trigger in the same order as the key inputs
    typedef struct packed {
        logic trigger;
        logic clear;
        logic extd_addr;
        logic addr_load;
        logic dep;
        logic exam;
        logic cont;
        logic dsel;
    } panel_cmd_t;

    // register set offered to the lamps, pc in the top word
    typedef struct packed {
        word_t pc;
        word_t ma;
        word_t mb;
        word_t ac;
        word_t fields;
        word_t sr;
    } panel_regs_t;

endpackage

`default_nettype wire

//--- hw/switch_conditioner.sv
`default_nettype none

module switch_conditioner #(
    parameter int hold_bits = panel_pkg::hold_bits_default
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [panel_pkg::key_count-1:0]     keys,
    output panel_pkg::panel_cmd_t               cmd,
    output logic                                busy,
    output logic [panel_pkg::display_count-1:0] dsel
);
    import panel_pkg::*;

    typedef enum logic [2:0] {
        st_latch,
        st_arm,
        st_pulse,
        st_rotate,
        st_settle,
        st_lockout,
        st_reenable
    } state_t;

    state_t state;
    logic [key_count-1:0] latched;
    panel_cmd_t armed_cmd;
    logic rotate_req;
    logic [hold_bits-1:0] hold_cnt;

    // command word built from whatever keys were caught in the latch
    assign armed_cmd = {1'b1, latched};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_latch;
            latched <= '0;
            rotate_req <= 1'b0;
            hold_cnt <= '0;
            cmd <= '0;
            busy <= 1'b0;
            dsel <= {1'b1, {(display_count - 1){1'b0}}};
        end
        else
        begin
            // the lockout counter runs for as long as busy is up
            if (busy)
            begin
                hold_cnt <= hold_cnt + 1'b1;
            end

            case (state)
                st_latch:
                begin
                    // presses pile up here, several keys may land in one command
                    latched <= latched | keys;
                    if (latched != '0)
                    begin
                        state <= st_arm;
                    end
                end
                st_arm:
                begin
                    cmd <= armed_cmd;
                    rotate_req <= armed_cmd.dsel;
                    latched <= '0;
                    state <= st_pulse;
                end
                st_pulse:
                begin
                    // cmd is high for this one cycle only
                    cmd <= '0;
                    busy <= 1'b1;
                    hold_cnt <= '0;
                    state <= st_rotate;
                end
                st_rotate:
                begin
                    // advance to the next display source, pc wraps in after sr
                    if (rotate_req)
                    begin
                        dsel <= {dsel[0], dsel[display_count-1:1]};
                    end
                    rotate_req <= 1'b0;
                    state <= st_settle;
                end
                st_settle:
                begin
                    // console and display are steady from here on
                    state <= st_lockout;
                end
                st_lockout:
                begin
                    if (hold_cnt == '1)
                    begin
                        busy <= 1'b0;
                        state <= st_reenable;
                    end
                end
                st_reenable:
                begin
                    // one quiet cycle before new presses are taken
                    state <= st_latch;
                end
                default:
                begin
                    state <= st_latch;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/panel_console.sv
`default_nettype none

module panel_console (
    input  logic                   clk,
    input  logic                   reset,
    input  panel_pkg::panel_cmd_t  cmd,
    input  panel_pkg::word_t       sr,
    output panel_pkg::panel_regs_t regs,
    output logic                   run_req
);
    import panel_pkg::*;

    word_t pc;
    word_t ma;
    word_t mb;
    logic [field_bits-1:0] inst_field;
    logic [field_bits-1:0] data_field;

    word_t mem [mem_words];
    word_t rd_word;
    logic exam_pending;

    logic [addr_bits-1:0] addr;
    logic do_dep;
    logic do_exam;

    // deposit and examine both work at the current pc
    assign addr = pc[addr_bits-1:0];
    assign do_dep = cmd.trigger & cmd.dep;
    assign do_exam = cmd.trigger & cmd.exam;

    // core memory with a registered read port
    always_ff @(posedge clk)
    begin
        if (do_dep)
        begin
            mem[addr] <= sr;
        end
        rd_word <= mem[addr];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
            ma <= '0;
            mb <= '0;
            inst_field <= '0;
            data_field <= '0;
            exam_pending <= 1'b0;
            run_req <= 1'b0;
        end
        else
        begin
            run_req <= cmd.trigger & cmd.cont;

            // the examined word comes back one cycle after the command
            exam_pending <= do_exam;
            if (exam_pending)
            begin
                mb <= rd_word;
            end

            if (cmd.trigger)
            begin
                if (cmd.clear)
                begin
                    mb <= '0;
                end

                if (cmd.extd_addr)
                begin
                    inst_field <= sr[2*field_bits-1:field_bits];
                    data_field <= sr[field_bits-1:0];
                end

                if (cmd.addr_load)
                begin
                    pc <= sr;
                end

                // a deposit or examine in the same command overrides the loaded pc
                // with the incremented old pc
                if (cmd.dep)
                begin
                    ma <= pc;
                    mb <= sr;
                    pc <= pc + 1'b1;
                end

                if (cmd.exam)
                begin
                    ma <= pc;
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    assign regs.pc = pc;
    assign regs.ma = ma;
    assign regs.mb = mb;
    // only the processor loads the accumulator, so the console always shows it cleared
    assign regs.ac = '0;
    assign regs.fields = {{(word_bits - 2 * field_bits){1'b0}}, inst_field, data_field};
    assign regs.sr = sr;

endmodule

`default_nettype wire

//--- hw/display_select.sv
`default_nettype none

module display_select (
    input  logic [panel_pkg::display_count-1:0] dsel,
    input  panel_pkg::panel_regs_t              regs,
    output panel_pkg::word_t                    lamps,
    output logic [panel_pkg::led_bits-1:0]      dsel_led
);
    import panel_pkg::*;

    // register lamps follow the one-hot selection, anything odd shows pc
    always_comb
    begin
        case (dsel)
            6'b100000: lamps = regs.pc;
            6'b010000: lamps = regs.ma;
            6'b001000: lamps = regs.mb;
            6'b000100: lamps = regs.ac;
            6'b000010: lamps = regs.fields;
            6'b000001: lamps = regs.sr;
            default:   lamps = regs.pc;
        endcase
    end

    // indicator lamps, matching the fallback above
    always_comb
    begin
        case (dsel)
            6'b100000: dsel_led = led_pc;
            6'b010000: dsel_led = led_ma;
            6'b001000: dsel_led = led_mb;
            6'b000100: dsel_led = led_ac;
            6'b000010: dsel_led = led_fields;
            6'b000001: dsel_led = led_sr;
            default:   dsel_led = led_pc;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/panel_top.sv
`default_nettype none

module panel_top #(
    parameter int hold_bits = panel_pkg::hold_bits_default
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [panel_pkg::key_count-1:0] keys,
    input  panel_pkg::word_t                sr,
    output panel_pkg::word_t                lamps,
    output logic [panel_pkg::led_bits-1:0]  dsel_led,
    output logic                            run_req,
    output logic                            busy
);
    import panel_pkg::*;

    panel_cmd_t cmd;
    panel_regs_t regs;
    logic [display_count-1:0] dsel;

    switch_conditioner #(
        .hold_bits (hold_bits)
    ) u_switch_conditioner (
        .clk   (clk),
        .reset (reset),
        .keys  (keys),
        .cmd   (cmd),
        .busy  (busy),
        .dsel  (dsel)
    );

    panel_console u_panel_console (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .sr      (sr),
        .regs    (regs),
        .run_req (run_req)
    );

    display_select u_display_select (
        .dsel     (dsel),
        .regs     (regs),
        .lamps    (lamps),
        .dsel_led (dsel_led)
    );

endmodule

`default_nettype wire

//--- tests/panel_tb.sv
`default_nettype none

module panel_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import panel_pkg::*;

    localparam int clk_period = 40;
    localparam int reset_cycles = 10;
    localparam int tb_hold_bits = 4;
    localparam int max_lines = 64;
    localparam int fields_per_line = 5;
    localparam int watchdog_cycles_per_line = 40;
    localparam string trace_path = "tests/panel_trace.txt";

    logic clk;
    logic reset;
    logic [key_count-1:0] keys;
    word_t sr;
    word_t lamps;
    logic [led_bits-1:0] dsel_led;
    logic run_req;
    logic busy;

    logic [15:0] trace_mem [max_lines * fields_per_line];
    int line_count = 0;
    logic trace_loaded = 1'b0;

    int run_count = 0;
    int press_count = 0;
    int busy_cycles = 0;
    logic busy_q = 1'b0;

    panel_top #(
        .hold_bits (tb_hold_bits)
    ) u_panel_top (
        .clk      (clk),
        .reset    (reset),
        .keys     (keys),
        .sr       (sr),
        .lamps    (lamps),
        .dsel_led (dsel_led),
        .run_req  (run_req),
        .busy     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h",
                               $time, name, expected, actual));
        end
    endtask

    // unused entries keep an address-derived pattern with the top nibble set,
    // so the first such key field marks the end of the trace
    task automatic load_trace();
        int i;
        for (i = 0; i < max_lines * fields_per_line; i++)
        begin
            trace_mem[i] = 16'hf000 | 16'(i);
        end
        $readmemh(trace_path, trace_mem);
        line_count = 0;
        while (line_count < max_lines &&
               trace_mem[line_count * fields_per_line][15:12] != 4'hf)
        begin
            line_count++;
        end
    endtask

    task automatic press_keys(input logic [key_count-1:0] mask, input word_t value);
        @(negedge clk);
        sr = value;
        keys = mask;
        @(negedge clk);
        keys = '0;
    endtask

    // the conditioner needs one quiet cycle after busy falls,
    // and the next press is driven one falling edge after this one
    task automatic wait_lockout();
        wait (busy === 1'b1);
        wait (busy === 1'b0);
        @(negedge clk);
    endtask

    // count run requests and accepted presses where the outputs are steady
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (run_req === 1'b1)
            begin
                run_count++;
            end
            if (busy === 1'b1)
            begin
                busy_cycles++;
            end
            if (busy === 1'b1 && busy_q !== 1'b1)
            begin
                press_count++;
            end
            if (busy !== 1'b1 && busy_q === 1'b1)
            begin
                // every lockout lasts 2**hold_bits cycles
                check_value("busy cycles", 16'(1 << tb_hold_bits), 16'(busy_cycles));
                busy_cycles = 0;
            end
            busy_q = busy;
        end
    end

    initial
    begin
        wait (trace_loaded === 1'b1);
        #(line_count * watchdog_cycles_per_line * clk_period);
        fail_run("timeout: the trace did not finish in the expected time");
    end

    initial
    begin
        int line_idx;
        int base;
        int expected_runs;
        logic [key_count-1:0] mask;
        word_t value;
        logic [15:0] run_flag;
        word_t exp_lamps;
        logic [led_bits-1:0] exp_led;

        keys = '0;
        sr = '0;
        reset = 1'b1;
        expected_runs = 0;

        load_trace();
        if (line_count == 0)
        begin
            fail_run("the trace file holds no key presses");
        end
        trace_loaded = 1'b1;

        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // after reset the lamps show a zero pc
        check_value("lamps after reset", 16'h000, 16'(lamps));
        check_value("dsel_led after reset", 16'h0c, 16'(dsel_led));

        for (line_idx = 0; line_idx < line_count; line_idx++)
        begin
            base = line_idx * fields_per_line;
            mask = trace_mem[base][key_count-1:0];
            value = trace_mem[base + 1][word_bits-1:0];
            run_flag = trace_mem[base + 2];
            exp_lamps = trace_mem[base + 3][word_bits-1:0];
            exp_led = trace_mem[base + 4][led_bits-1:0];

            press_keys(mask, value);
            wait_lockout();

            expected_runs += int'(run_flag);
            check_value($sformatf("lamps, trace line %0d", line_idx + 1),
                        16'(exp_lamps), 16'(lamps));
            check_value($sformatf("dsel_led, trace line %0d", line_idx + 1),
                        16'(exp_led), 16'(dsel_led));
            check_value($sformatf("run_req count, trace line %0d", line_idx + 1),
                        16'(expected_runs), 16'(run_count));
        end

        check_value("accepted presses", 16'(line_count), 16'(press_count));
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/panel_trace.txt
// keys sr run_req lamps dsel_led, one key press per line, all hex
// keys: 40 clear, 20 extd addr, 10 load addr, 08 dep, 04 exam, 02 cont, 01 dsel
// load address 0o1234 with pc on the lamps
10 29C 0 29C 0C
// deposit three words from 0o0100 and go back to the start
10 040 0 040 0C
08 123 0 041 0C
08 456 0 042 0C
08 789 0 043 0C
10 040 0 040 0C
// rotate to mb and examine the words back
01 000 0 042 0A
01 000 0 789 09
04 000 0 123 09
04 000 0 456 09
04 000 0 789 09
// walk the selector round once, sr shows the switches
01 000 0 000 14
01 000 0 000 12
01 5A5 0 5A5 11
01 000 0 043 0C
01 000 0 042 0A
01 000 0 789 09
// fields from extended address 0o0053, then clear mb
01 000 0 000 14
20 02B 0 000 14
01 02B 0 02B 12
01 000 0 000 11
01 000 0 043 0C
01 000 0 042 0A
01 000 0 789 09
40 000 0 000 09
// continue pulses run_req and leaves the registers alone
02 000 1 000 09
01 000 0 000 14
01 000 0 02B 12
01 000 0 000 11
01 000 0 043 0C
// load address with deposit in one press, deposit works from the old pc
18 0A0 0 044 0C
01 000 0 043 0A
01 000 0 0A0 09
10 043 0 0A0 09
04 000 0 0A0 09
// select and continue together
03 000 1 000 14

//--- all.f
hw/panel_pkg.sv
hw/switch_conditioner.sv
hw/panel_console.sv
hw/display_select.sv
hw/panel_top.sv
tests/panel_tb.sv

//--- Makefile
# Verilator flow for the operator console testbench

VERILATOR ?= verilator
FILE_LIST ?= all.f
TB_TOP ?= panel_tb
RTL_TOP ?= panel_top
OBJ_DIR ?= obj_dir
SIM_BIN ?= panel_sim
LINT_FLAGS ?=
BUILD_FLAGS ?= -O2
PASS_MSG ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary --timing $(BUILD_FLAGS) -f $(FILE_LIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o $(SIM_BIN)

# the run passes only when the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
